/* Makefile */
# Verilator build and run of the convolution window testbench

SIM = obj_dir/conv_window_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  --top-module conv_window_tb -f all.f --Mdir obj_dir -o conv_window_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
hdl/conv_arith_pkg.sv
hdl/conv_ctrl_pkg.sv
hdl/cla_adder.sv
hdl/signed_mult_pipe.sv
hdl/mac_pe.sv
hdl/requant_relu.sv
hdl/window_sequencer.sv
hdl/conv_window_top.sv
verif/conv_window_assert.sv
verif/conv_window_tb.sv

/* hdl/cla_adder.sv */
// 28-bit carry-lookahead adder of 4-bit groups with a second-level carry unit
`default_nettype none

module cla_adder (
  input  conv_arith_pkg::acc_t a,
  input  conv_arith_pkg::acc_t b,
  output conv_arith_pkg::acc_t sum
);

  localparam int gw     = conv_arith_pkg::cla_group_w;
  localparam int groups = conv_arith_pkg::acc_w / gw;

  logic [groups-1:0] grp_p;  // group propagate
  logic [groups-1:0] grp_g;  // group generate
  logic [groups-1:0] grp_c;  // carry into each group

  ////////////////////////////////////////////////////////////
  // 4-bit lookahead groups
  ////////////////////////////////////////////////////////////
  for (genvar k = 0; k < groups; k++) begin : g_grp
    logic [gw-1:0] bp;
    logic [gw-1:0] bg;
    logic [gw-1:0] c;
    logic          grp_gen;

    assign bp = a[k*gw +: gw] ^ b[k*gw +: gw];
    assign bg = a[k*gw +: gw] & b[k*gw +: gw];

    // generate out of the group with no carry in
    always_comb begin
      grp_gen = 1'b0;
      for (int i = 0; i < gw; i++) begin
        grp_gen = bg[i] | (bp[i] & grp_gen);
      end
    end

    assign grp_p[k] = &bp;
    assign grp_g[k] = grp_gen;

    always_comb begin
      c[0] = grp_c[k];
      for (int i = 0; i < gw - 1; i++) begin
        c[i+1] = bg[i] | (bp[i] & c[i]);
      end
    end

    assign sum[k*gw +: gw] = bp ^ c;
  end

  ////////////////////////////////////////////////////////////
  // second-level carry unit
  ////////////////////////////////////////////////////////////
  always_comb begin
    grp_c[0] = 1'b0;  // add only
    for (int k = 0; k < groups - 1; k++) begin
      grp_c[k+1] = grp_g[k] | (grp_p[k] & grp_c[k]);
    end
  end

endmodule

`default_nettype wire

/* hdl/conv_arith_pkg.sv */
// arithmetic widths, tap and accumulator types, requantization constants
`default_nettype none

package conv_arith_pkg;

  ////////////////////////////////////////////////////////////
  // operand and product widths
  ////////////////////////////////////////////////////////////
  localparam int tap_w  = 8;   // one feature or weight tap
  localparam int prod_w = 16;  // full signed 8x8 product

  typedef logic signed [tap_w-1:0] tap_t;

  ////////////////////////////////////////////////////////////
  // accumulator and adder
  ////////////////////////////////////////////////////////////
  localparam int acc_w       = 28;
  localparam int cla_group_w = 4;  // bits per lookahead group

  typedef logic signed [acc_w-1:0] acc_t;

  ////////////////////////////////////////////////////////////
  // requantization
  ////////////////////////////////////////////////////////////
  // bias is aligned to the product scale before it is added
  localparam int bias_shift = 6;
  localparam int pixel_w    = 8;
  localparam int pixel_max  = 127;  // relu ceiling, 7-bit pixel

endpackage

`default_nettype wire

/* hdl/conv_ctrl_pkg.sv */
// window geometry, pipeline depth, sequencer states and window/result records
`default_nettype none

package conv_ctrl_pkg;

  localparam int win_taps    = 9;  // 3x3 window
  localparam int mult_stages = 8;  // register stages of the multiplier
  localparam int seq_cnt_w   = $clog2(win_taps);

  typedef enum logic [1:0] {
    idle,
    feed,   // taps go into the pe
    drain,  // pipeline empties into the accumulator
    emit    // requantizer captures the sum
  } seq_state_e;

  // tap 0 sits in the most significant byte of each vector
  typedef struct packed {
    conv_arith_pkg::tap_t [0:win_taps-1] feat;
    conv_arith_pkg::tap_t [0:win_taps-1] weight;
    conv_arith_pkg::tap_t                bias;
  } window_t;

  typedef struct packed {
    logic [conv_arith_pkg::pixel_w-1:0] pixel;
    conv_arith_pkg::acc_t               dot;  // raw dot product before bias
  } conv_result_t;

endpackage

`default_nettype wire

/* hdl/conv_window_top.sv */
// 3x3 convolution window engine: sequencer, multiply-accumulate pe and requantizer
`default_nettype none

module conv_window_top (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start,
  input  conv_ctrl_pkg::window_t      window,
  output logic                        busy,
  output logic                        done,
  output conv_ctrl_pkg::conv_result_t result
);

  logic                 pe_en;
  logic                 first;
  logic                 capture;
  conv_arith_pkg::tap_t feat_tap;
  conv_arith_pkg::tap_t weight_tap;
  conv_arith_pkg::tap_t bias;
  conv_arith_pkg::acc_t acc;

  window_sequencer u_seq (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .window     (window),
    .busy       (busy),
    .done       (done),
    .pe_en      (pe_en),
    .first      (first),
    .feat_tap   (feat_tap),
    .weight_tap (weight_tap),
    .bias       (bias),
    .capture    (capture)
  );

  mac_pe u_pe (
    .clk        (clk),
    .rstn       (rstn),
    .en         (pe_en),
    .first      (first),
    .feat_tap   (feat_tap),
    .weight_tap (weight_tap),
    .acc        (acc)
  );

  requant_relu u_requant (
    .clk     (clk),
    .rstn    (rstn),
    .capture (capture),
    .acc     (acc),
    .bias    (bias),
    .result  (result)
  );

endmodule

`default_nettype wire

/* hdl/mac_pe.sv */
// processing element: pipelined multiply with first-flag restart of the 28-bit accumulator
`default_nettype none

module mac_pe (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 en,
  input  logic                 first,
  input  conv_arith_pkg::tap_t feat_tap,
  input  conv_arith_pkg::tap_t weight_tap,
  output conv_arith_pkg::acc_t acc
);

  localparam int depth = conv_ctrl_pkg::mult_stages;

  logic signed [conv_arith_pkg::prod_w-1:0] product;
  logic [depth-1:0]     first_q;   // first flag, aligned with the product
  conv_arith_pkg::acc_t prod_ext;
  conv_arith_pkg::acc_t acc_base;
  conv_arith_pkg::acc_t acc_next;

  signed_mult_pipe u_mult (
    .clk     (clk),
    .en      (en),
    .a       (feat_tap),
    .b       (weight_tap),
    .product (product)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      first_q <= '0;
    end else if (en) begin
      first_q <= {first_q[depth-2:0], first};
    end
  end

  assign prod_ext = conv_arith_pkg::acc_t'(product);        // sign extend
  assign acc_base = first_q[depth-1] ? '0 : acc;            // restart on tap 0

  cla_adder u_acc_add (
    .a   (prod_ext),
    .b   (acc_base),
    .sum (acc_next)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc <= '0;
    end else if (en) begin
      acc <= acc_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/requant_relu.sv */
// adds the aligned bias and clamps the sum relu-style to a 7-bit pixel
`default_nettype none

module requant_relu (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        capture,
  input  conv_arith_pkg::acc_t        acc,
  input  conv_arith_pkg::tap_t        bias,
  output conv_ctrl_pkg::conv_result_t result
);

  localparam int aw = conv_arith_pkg::acc_w;
  localparam int tw = conv_arith_pkg::tap_w;
  localparam int sh = conv_arith_pkg::bias_shift;
  localparam int pw = conv_arith_pkg::pixel_w;

  conv_arith_pkg::acc_t bias_ext;
  conv_arith_pkg::acc_t biased;
  logic [pw-1:0]        pixel;

  assign bias_ext = {{(aw - tw - sh){bias[tw-1]}}, bias, {sh{1'b0}}};  // bias * 64

  cla_adder u_bias_add (
    .a   (acc),
    .b   (bias_ext),
    .sum (biased)
  );

  always_comb begin
    if (biased[aw-1]) begin
      pixel = '0;                                   // negative
    end else if (|biased[aw-2:sh+pw-1]) begin
      pixel = pw'(conv_arith_pkg::pixel_max);       // saturate
    end else begin
      pixel = {1'b0, biased[sh+pw-2:sh]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      result <= '0;
    end else if (capture) begin
      result.pixel <= pixel;
      result.dot   <= acc;
    end
  end

endmodule

`default_nettype wire

/* hdl/signed_mult_pipe.sv */
// eight-stage signed 8x8 multiplier, magnitude partial products and split low/high reduction
`default_nettype none

module signed_mult_pipe (
  input  logic                                       clk,
  input  logic                                       en,
  input  conv_arith_pkg::tap_t                       a,
  input  conv_arith_pkg::tap_t                       b,
  output logic signed [conv_arith_pkg::prod_w-1:0]   product
);

  logic [7:0]  a_mag;
  logic [7:0]  b_mag;
  logic [7:0]  pp [8];
  logic [7:0]  pp_q [8];
  logic [5:0]  lsb2_q [4];
  logic [2:0]  hi2_even_q [4];
  logic [3:0]  hi2_odd_q [4];
  logic [9:0]  sum3_q [4];
  logic [7:0]  lsb4_q [2];
  logic [2:0]  hi4_even_q [2];
  logic [4:0]  hi4_odd_q [2];
  logic [11:0] sum5_q [2];
  logic [9:0]  lsb6_q;
  logic [2:0]  hi6_even_q;
  logic [6:0]  hi6_odd_q;
  logic [15:0] sum7_q;       // unsigned magnitude of the product
  logic [6:0]  sign_q;       // sign travels beside stages 1 to 7

  ////////////////////////////////////////////////////////////
  // stage 1: magnitudes and partial products
  ////////////////////////////////////////////////////////////
  assign a_mag = a[7] ? ~a + 1'b1 : a;  // -128 maps to 8'h80
  assign b_mag = b[7] ? ~b + 1'b1 : b;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      pp[i] = b_mag[i] ? a_mag : 8'h00;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      pp_q   <= pp;
      sign_q <= {sign_q[5:0], a[7] ^ b[7]};
    end
  end

  ////////////////////////////////////////////////////////////
  // stages 2 and 3: pairs at shift one
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (en) begin
      for (int j = 0; j < 4; j++) begin
        lsb2_q[j]     <= pp_q[2*j][4:0] + {pp_q[2*j+1][3:0], 1'b0};
        hi2_even_q[j] <= pp_q[2*j][7:5];
        hi2_odd_q[j]  <= pp_q[2*j+1][7:4];
        // high part picks up the low carry
        sum3_q[j] <= {5'(hi2_even_q[j] + hi2_odd_q[j] + lsb2_q[j][5]), lsb2_q[j][4:0]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stages 4 and 5: pairs at shift two
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (en) begin
      for (int m = 0; m < 2; m++) begin
        lsb4_q[m]     <= sum3_q[2*m][6:0] + {sum3_q[2*m+1][4:0], 2'b00};
        hi4_even_q[m] <= sum3_q[2*m][9:7];
        hi4_odd_q[m]  <= sum3_q[2*m+1][9:5];
        sum5_q[m] <= {5'(hi4_even_q[m] + hi4_odd_q[m] + lsb4_q[m][7]), lsb4_q[m][6:0]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stages 6 and 7: last pair at shift four
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (en) begin
      lsb6_q     <= sum5_q[0][8:0] + {sum5_q[1][4:0], 4'h0};
      hi6_even_q <= sum5_q[0][11:9];
      hi6_odd_q  <= sum5_q[1][11:5];
      sum7_q     <= {7'(hi6_even_q + hi6_odd_q + lsb6_q[9]), lsb6_q[8:0]};
    end
  end

  // stage 8: restore the sign
  always_ff @(posedge clk) begin
    if (en) begin
      product <= sign_q[6] ? ~sum7_q + 1'b1 : sum7_q;
    end
  end

endmodule

`default_nettype wire

/* hdl/window_sequencer.sv */
// FSM that latches a 3x3 window, feeds its taps into the pe, drains the pipeline and signals done
`default_nettype none

module window_sequencer (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   start,
  input  conv_ctrl_pkg::window_t window,
  output logic                   busy,
  output logic                   done,
  output logic                   pe_en,
  output logic                   first,
  output conv_arith_pkg::tap_t   feat_tap,
  output conv_arith_pkg::tap_t   weight_tap,
  output conv_arith_pkg::tap_t   bias,
  output logic                   capture
);

  localparam int tw     = conv_arith_pkg::tap_w;
  localparam int vec_w  = conv_ctrl_pkg::win_taps * tw;
  localparam int cnt_w  = conv_ctrl_pkg::seq_cnt_w;

  conv_ctrl_pkg::seq_state_e state;
  logic [cnt_w-1:0]          cnt;
  logic [vec_w-1:0]          feat_sr;    // tap 0 on top
  logic [vec_w-1:0]          weight_sr;

  ////////////////////////////////////////////////////////////
  // state and counters
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= conv_ctrl_pkg::idle;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= capture;  // lines up with the registered result
      case (state)
        conv_ctrl_pkg::idle: begin
          if (start) begin
            state <= conv_ctrl_pkg::feed;
            cnt   <= '0;
          end
        end
        conv_ctrl_pkg::feed: begin
          if (cnt == cnt_w'(conv_ctrl_pkg::win_taps - 1)) begin
            state <= conv_ctrl_pkg::drain;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        conv_ctrl_pkg::drain: begin
          // multiplier stages plus the accumulator register
          if (cnt == cnt_w'(conv_ctrl_pkg::mult_stages)) begin
            state <= conv_ctrl_pkg::emit;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        conv_ctrl_pkg::emit: state <= conv_ctrl_pkg::idle;
        default:             state <= conv_ctrl_pkg::idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // window operands
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (state == conv_ctrl_pkg::idle && start) begin
      feat_sr   <= window.feat;
      weight_sr <= window.weight;
      bias      <= window.bias;
    end else if (state == conv_ctrl_pkg::feed) begin
      feat_sr   <= feat_sr << tw;   // zeros follow the last tap
      weight_sr <= weight_sr << tw;
    end
  end

  assign feat_tap   = feat_sr[vec_w-1 -: tw];
  assign weight_tap = weight_sr[vec_w-1 -: tw];

  assign busy    = (state != conv_ctrl_pkg::idle);
  assign pe_en   = (state == conv_ctrl_pkg::feed) || (state == conv_ctrl_pkg::drain);
  assign first   = (state == conv_ctrl_pkg::feed) && (cnt == '0);
  assign capture = (state == conv_ctrl_pkg::emit);

endmodule

`default_nettype wire

/* verif/conv_window_assert.sv */
// checker of the done pulse, reset levels and pixel range of the window engine
`default_nettype none

module conv_window_assert (
  input logic                        clk,
  input logic                        rstn,
  input logic                        busy,
  input logic                        done,
  input conv_ctrl_pkg::conv_result_t result
);
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////
  // pulse and level rules
  ////////////////////////////////////////////////////////////
  done_one_cycle: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
    else $error("done held high for more than one cycle");

  // synchronous reset clears the levels one edge later
  reset_quiet: assert property (@(posedge clk) !rstn |=> (!busy && !done))
    else $error("busy or done high during reset");

  done_after_busy: assert property (@(posedge clk) disable iff (!rstn) done |-> $past(busy))
    else $error("done without busy in the cycle before");

  pixel_range: assert property (@(posedge clk) disable iff (!rstn) result.pixel <= 8'd127)
    else $error("pixel above the relu ceiling");

endmodule

`default_nettype wire

/* verif/conv_window_tb.sv */
// testbench for the 3x3 convolution window engine, directed and random windows
`default_nettype none

module conv_window_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_directed = 8;
  localparam int n_random   = 12;
  localparam int n_rows     = n_directed + n_random;
  localparam int half_per   = 50;
  localparam int done_lat   = 19;  // start edge to done edge
  localparam int done_limit = 40;  // give up on done after this many cycles
  localparam int wd_cycles  = n_rows * 25 + 16;

  typedef struct {
    string                       name;
    conv_ctrl_pkg::window_t      win;
    bit                          poke_busy;  // pulse start again while busy
    conv_ctrl_pkg::conv_result_t exp;
  } row_t;

  logic                        clk = 1'b0;
  logic                        rstn;
  logic                        start;
  conv_ctrl_pkg::window_t      window;
  logic                        busy;
  logic                        done;
  conv_ctrl_pkg::conv_result_t result;

  row_t rows [n_rows];
  int   errors;

  conv_window_top u_dut (
    .clk    (clk),
    .rstn   (rstn),
    .start  (start),
    .window (window),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  bind conv_window_top conv_window_assert u_chk (
    .clk    (clk),
    .rstn   (rstn),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  always #half_per clk = ~clk;

  ////////////////////////////////////////////////////////////
  // reference model and stimulus helpers
  ////////////////////////////////////////////////////////////
  function automatic conv_ctrl_pkg::conv_result_t expected_result(
    input conv_ctrl_pkg::window_t w
  );
    conv_ctrl_pkg::conv_result_t r;
    int dot;
    int sum;
    int f;
    int k;
    dot = 0;
    for (int i = 0; i < 9; i++) begin
      f   = $signed(w.feat[i]);
      k   = $signed(w.weight[i]);
      dot = dot + f * k;
    end
    sum = dot + $signed(w.bias) * 64;  // bias on the product scale
    if (sum < 0) begin
      r.pixel = 8'd0;
    end else if (sum >= (1 << 13)) begin
      r.pixel = 8'd127;                // saturate
    end else begin
      r.pixel = 8'(sum >> 6);
    end
    r.dot = conv_arith_pkg::acc_t'(dot);
    return r;
  endfunction

  function automatic conv_ctrl_pkg::window_t make_window(
    input logic [71:0] feat,
    input logic [71:0] weight,
    input logic [7:0]  bias
  );
    conv_ctrl_pkg::window_t w;
    w.feat   = feat;    // tap 0 in the top byte
    w.weight = weight;
    w.bias   = bias;
    return w;
  endfunction

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_row(input int idx, input string name, input conv_ctrl_pkg::window_t w,
                         input bit poke);
    rows[idx].name      = name;
    rows[idx].win       = w;
    rows[idx].poke_busy = poke;
    rows[idx].exp       = expected_result(w);
  endtask

  task automatic build_table();
    logic [31:0]            seed;
    conv_ctrl_pkg::window_t w;
    seed = 32'h0e54_bcf6;
    add_row(0, "zero_window", make_window(72'h0, 72'h0, 8'h00), 1'b0);
    add_row(1, "bias_only", make_window(72'h0, 72'h0, 8'h2d), 1'b0);
    add_row(2, "bias_clamp", make_window(72'h0, 72'h0, 8'h7f), 1'b0);
    add_row(3, "extreme_taps", make_window(72'h80_80_7f_01_ff_00_40_c0_10,
                                           72'h80_7f_80_ff_ff_55_c0_c0_f0, 8'h00), 1'b0);
    add_row(4, "negative_sum", make_window({9{8'h40}}, {9{8'hf0}}, 8'h20), 1'b0);
    add_row(5, "large_positive", make_window({9{8'h7f}}, {9{8'h7f}}, 8'h00), 1'b0);
    add_row(6, "in_range", make_window(72'h01_02_03_04_05_06_07_08_09,
                                       {9{8'h10}}, 8'h0a), 1'b0);
    add_row(7, "start_while_busy", make_window(72'h05_fb_0a_f6_14_ec_28_d8_50,
                                               72'h03_03_fd_02_fe_04_01_ff_02, 8'h05), 1'b1);
    for (int r = 0; r < n_random; r++) begin
      for (int b = 0; b < 19; b++) begin
        seed         = lcg_step(seed);
        w[b*8 +: 8] = seed[23:16];  // upper bits of the lcg are the better ones
      end
      add_row(n_directed + r, $sformatf("random_%0d", r), w, 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checks and sequencing
  ////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input string what,
                             input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %0d, actual %0d", name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic apply_reset();
    rstn = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    check_value("reset", "busy", 0, busy);
    check_value("reset", "done", 0, done);
    check_value("reset", "pixel", 0, result.pixel);
    check_value("reset", "dot", 0, result.dot);
    rstn = 1'b1;
  endtask

  // called on a falling edge, returns on the falling edge where done is seen
  task automatic run_row(input int idx);
    int cycles;
    int extra;
    start  = 1'b1;
    window = rows[idx].win;
    @(negedge clk);
    start  = 1'b0;
    window = '0;
    if (!busy) begin
      $display("busy did not rise after start in row %s", rows[idx].name);
      errors++;
    end
    cycles = 0;
    while (!done && cycles < done_limit) begin
      if (rows[idx].poke_busy && cycles == 4) begin
        start  = 1'b1;  // different window, must be ignored
        window = make_window({9{8'h7f}}, {9{8'h81}}, 8'h7f);
      end else begin
        start  = 1'b0;
        window = '0;
      end
      @(negedge clk);
      cycles++;
    end
    start = 1'b0;
    if (!done) begin
      $display("no done within %0d cycles after start in row %s", done_limit, rows[idx].name);
      errors++;
    end else begin
      check_value(rows[idx].name, "latency", done_lat, cycles);
      check_value(rows[idx].name, "pixel", rows[idx].exp.pixel, result.pixel);
      check_value(rows[idx].name, "dot", rows[idx].exp.dot, result.dot);
      check_value(rows[idx].name, "busy at done", 0, busy);
    end
    if (rows[idx].poke_busy) begin
      extra = 0;
      repeat (done_lat + 1) begin
        @(negedge clk);
        if (done) extra++;
      end
      check_value(rows[idx].name, "extra done pulses", 0, extra);
      check_value(rows[idx].name, "held pixel", rows[idx].exp.pixel, result.pixel);
    end
  endtask

  initial begin
    rstn   = 1'b0;
    start  = 1'b0;
    window = '0;
    errors = 0;
    build_table();
    apply_reset();
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);  // next start follows done directly
    end
    repeat (2) @(negedge clk);
    $display("rows run: %0d, errors: %0d", n_rows, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(wd_cycles * 2 * half_per);
    $display("timeout: run did not finish within %0d cycles", wd_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
